// ==== retire_config.svh ====
`ifndef RETIRE_CONFIG_SVH
`define RETIRE_CONFIG_SVH

// ############################################################
// Field widths of the retire stage
// ############################################################

// Register indices
`define RETIRE_ARCH_REG_W  5            // x0..x31
`define RETIRE_PHY_REG_W   6            // Physical register file, 64 entries

// Store queue
`define RETIRE_STORE_ID_W  4            // 16 store queue slots

// Program counter and instruction fields
`define RETIRE_ADDR_W      32
`define RETIRE_OPCODE_W    7            // Major opcode, inst[6:0]

// Retire class and retire count
`define RETIRE_CLASS_W     3
`define RETIRE_NUM_W       2            // Counts 0, 1 or 2 entries

`endif

// ==== retire_pkg.sv ====
`include "retire_config.svh"
`default_nettype none

package retire_pkg;

    // RISC-V major opcodes, standard encodings
    typedef enum logic [`RETIRE_OPCODE_W-1:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [`RETIRE_CLASS_W-1:0] {
        CLASS_ALU    = 3'd0,
        CLASS_LOAD   = 3'd1,
        CLASS_STORE  = 3'd2,
        CLASS_BRANCH = 3'd3,
        CLASS_JUMP   = 3'd4,
        CLASS_SYSTEM = 3'd5,
        CLASS_OTHER  = 3'd6             // Unknown opcode, retires with no effect
    } inst_class_e;

    typedef logic [`RETIRE_ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [`RETIRE_PHY_REG_W-1:0]  phy_reg_t;
    typedef logic [`RETIRE_STORE_ID_W-1:0] store_id_t;
    typedef logic [`RETIRE_ADDR_W-1:0]     addr_t;
    typedef logic [`RETIRE_NUM_W-1:0]      retire_num_t;

endpackage

`default_nettype wire

// ==== retire_slot_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module retire_slot_decode
    import retire_pkg::*;
(
    input  opcode_e     opcode,
    input  arch_reg_t   rd_arch,
    input  phy_reg_t    rd_phy_old,
    input  phy_reg_t    rd_phy_new,
    input  store_id_t   store_id,
    input  addr_t       update_pc,
    input  addr_t       actual_target,
    input  logic        actual_taken,
    input  logic        mispredict,

    output inst_class_e inst_class,
    output logic        pr_valid,
    output arch_reg_t   rd_arch_out,
    output phy_reg_t    rd_phy_old_out,
    output phy_reg_t    rd_phy_new_out,
    output logic        store_valid,
    output store_id_t   store_id_out,
    output logic        branch_valid,
    output addr_t       btb_pc,
    output logic        btb_taken,
    output addr_t       btb_target,
    output logic        redirect,
    output addr_t       redirect_pc,
    output logic        done_valid
);

    // ############################################################
    // Opcode classification
    // ############################################################

    always_comb begin
        case (opcode)
            OP_IMM, OP, LUI, AUIPC: inst_class = CLASS_ALU;
            LOAD:                   inst_class = CLASS_LOAD;
            STORE:                  inst_class = CLASS_STORE;
            BRANCH:                 inst_class = CLASS_BRANCH;
            JAL, JALR:              inst_class = CLASS_JUMP;
            SYSTEM:                 inst_class = CLASS_SYSTEM;
            default:                inst_class = CLASS_OTHER;
        endcase
    end

    // ############################################################
    // Retire record, only the fields of the class are set
    // ############################################################

    always_comb begin
        pr_valid       = 1'b0;
        rd_arch_out    = '0;
        rd_phy_old_out = '0;
        rd_phy_new_out = '0;
        store_valid    = 1'b0;
        store_id_out   = '0;
        branch_valid   = 1'b0;
        btb_pc         = '0;
        btb_taken      = 1'b0;
        btb_target     = '0;
        redirect       = 1'b0;
        redirect_pc    = '0;
        done_valid     = 1'b0;

        case (inst_class)
            CLASS_ALU, CLASS_LOAD: begin
                pr_valid       = 1'b1;
                rd_arch_out    = rd_arch;
                rd_phy_old_out = rd_phy_old;
                rd_phy_new_out = rd_phy_new;
            end
            CLASS_STORE: begin
                store_valid  = 1'b1;
                store_id_out = store_id;
            end
            CLASS_BRANCH, CLASS_JUMP: begin
                branch_valid = 1'b1;
                btb_pc       = update_pc;
                btb_taken    = actual_taken;
                btb_target   = actual_target;
                redirect     = mispredict;
                redirect_pc  = mispredict ? actual_target : '0;
                // Link register write, x0 is never renamed
                if (inst_class == CLASS_JUMP && rd_arch != '0) begin
                    pr_valid       = 1'b1;
                    rd_arch_out    = rd_arch;
                    rd_phy_old_out = rd_phy_old;
                    rd_phy_new_out = rd_phy_new;
                end
            end
            CLASS_SYSTEM: done_valid = 1'b1;
            default: ;                      // CLASS_OTHER keeps the all-zero record
        endcase
    end

endmodule

`default_nettype wire

// ==== retire_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module retire_select
    import retire_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        finish_0,
    input  logic        finish_1,

    // Ungated records from the slot decoders
    input  inst_class_e dec_inst_class_0, dec_inst_class_1,
    input  logic        dec_pr_valid_0, dec_pr_valid_1,
    input  arch_reg_t   dec_rd_arch_0, dec_rd_arch_1,
    input  phy_reg_t    dec_rd_phy_old_0, dec_rd_phy_old_1,
    input  phy_reg_t    dec_rd_phy_new_0, dec_rd_phy_new_1,
    input  logic        dec_store_valid_0, dec_store_valid_1,
    input  store_id_t   dec_store_id_0, dec_store_id_1,
    input  logic        dec_branch_valid_0, dec_branch_valid_1,
    input  addr_t       dec_btb_pc_0, dec_btb_pc_1,
    input  logic        dec_btb_taken_0, dec_btb_taken_1,
    input  addr_t       dec_btb_target_0, dec_btb_target_1,
    input  logic        dec_redirect_0, dec_redirect_1,
    input  addr_t       dec_redirect_pc_0, dec_redirect_pc_1,
    input  logic        dec_done_valid_0, dec_done_valid_1,

    // Registered retire bus
    output retire_num_t retire_num,
    output logic        pr_valid_0, pr_valid_1,
    output arch_reg_t   rd_arch_0_out, rd_arch_1_out,
    output phy_reg_t    rd_phy_old_0_out, rd_phy_old_1_out,
    output phy_reg_t    rd_phy_new_0_out, rd_phy_new_1_out,
    output logic        store_valid_0, store_valid_1,
    output store_id_t   store_id_0_out, store_id_1_out,
    output logic        branch_valid_0, branch_valid_1,
    output addr_t       btb_pc_0, btb_pc_1,
    output logic        btb_taken_0, btb_taken_1,
    output addr_t       btb_target_0, btb_target_1,
    output logic        redirect_0, redirect_1,
    output addr_t       redirect_pc_0, redirect_pc_1,
    output logic        done_valid_0, done_valid_1
);

    logic pair_block;
    logic take_0;
    logic take_1;

    // ############################################################
    // Retire decision
    // ############################################################

    // Same-class pairs of these share a single port downstream
    assign pair_block = ((dec_inst_class_0 == dec_inst_class_1) &&
                         (dec_inst_class_0 inside {CLASS_STORE, CLASS_BRANCH,
                                                   CLASS_JUMP, CLASS_SYSTEM})) ||
                        dec_redirect_0;         // Younger entry is flushed by the redirect

    assign take_0 = !flush && finish_0;
    assign take_1 = !flush && finish_0 && finish_1 && !pair_block;

    // ############################################################
    // Output register
    // ############################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_num       <= '0;
            pr_valid_0       <= 1'b0;
            rd_arch_0_out    <= '0;
            rd_phy_old_0_out <= '0;
            rd_phy_new_0_out <= '0;
            store_valid_0    <= 1'b0;
            store_id_0_out   <= '0;
            branch_valid_0   <= 1'b0;
            btb_pc_0         <= '0;
            btb_taken_0      <= 1'b0;
            btb_target_0     <= '0;
            redirect_0       <= 1'b0;
            redirect_pc_0    <= '0;
            done_valid_0     <= 1'b0;
            pr_valid_1       <= 1'b0;
            rd_arch_1_out    <= '0;
            rd_phy_old_1_out <= '0;
            rd_phy_new_1_out <= '0;
            store_valid_1    <= 1'b0;
            store_id_1_out   <= '0;
            branch_valid_1   <= 1'b0;
            btb_pc_1         <= '0;
            btb_taken_1      <= 1'b0;
            btb_target_1     <= '0;
            redirect_1       <= 1'b0;
            redirect_pc_1    <= '0;
            done_valid_1     <= 1'b0;
        end else begin
            retire_num       <= take_1 ? 2'd2 : (take_0 ? 2'd1 : 2'd0);
            // Head entry
            pr_valid_0       <= take_0 && dec_pr_valid_0;
            rd_arch_0_out    <= take_0 ? dec_rd_arch_0 : '0;
            rd_phy_old_0_out <= take_0 ? dec_rd_phy_old_0 : '0;
            rd_phy_new_0_out <= take_0 ? dec_rd_phy_new_0 : '0;
            store_valid_0    <= take_0 && dec_store_valid_0;
            store_id_0_out   <= take_0 ? dec_store_id_0 : '0;
            branch_valid_0   <= take_0 && dec_branch_valid_0;
            btb_pc_0         <= take_0 ? dec_btb_pc_0 : '0;
            btb_taken_0      <= take_0 && dec_btb_taken_0;
            btb_target_0     <= take_0 ? dec_btb_target_0 : '0;
            redirect_0       <= take_0 && dec_redirect_0;
            redirect_pc_0    <= take_0 ? dec_redirect_pc_0 : '0;
            done_valid_0     <= take_0 && dec_done_valid_0;
            // Head+1 entry
            pr_valid_1       <= take_1 && dec_pr_valid_1;
            rd_arch_1_out    <= take_1 ? dec_rd_arch_1 : '0;
            rd_phy_old_1_out <= take_1 ? dec_rd_phy_old_1 : '0;
            rd_phy_new_1_out <= take_1 ? dec_rd_phy_new_1 : '0;
            store_valid_1    <= take_1 && dec_store_valid_1;
            store_id_1_out   <= take_1 ? dec_store_id_1 : '0;
            branch_valid_1   <= take_1 && dec_branch_valid_1;
            btb_pc_1         <= take_1 ? dec_btb_pc_1 : '0;
            btb_taken_1      <= take_1 && dec_btb_taken_1;
            btb_target_1     <= take_1 ? dec_btb_target_1 : '0;
            redirect_1       <= take_1 && dec_redirect_1;
            redirect_pc_1    <= take_1 ? dec_redirect_pc_1 : '0;
            done_valid_1     <= take_1 && dec_done_valid_1;
        end
    end

endmodule

`default_nettype wire

// ==== retire_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module retire_unit
    import retire_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,

    // Two oldest ROB entries, head and head+1
    input  logic        finish_0, finish_1,
    input  opcode_e     opcode_0, opcode_1,
    input  arch_reg_t   rd_arch_0, rd_arch_1,
    input  phy_reg_t    rd_phy_old_0, rd_phy_old_1,
    input  phy_reg_t    rd_phy_new_0, rd_phy_new_1,
    input  store_id_t   store_id_0, store_id_1,
    input  addr_t       update_pc_0, update_pc_1,
    input  logic        actual_taken_0, actual_taken_1,
    input  addr_t       actual_target_0, actual_target_1,
    input  logic        mispredict_0, mispredict_1,

    // Retire bus, count goes back to the ROB
    output retire_num_t retire_num,
    output logic        pr_valid_0, pr_valid_1,
    output arch_reg_t   rd_arch_0_out, rd_arch_1_out,
    output phy_reg_t    rd_phy_old_0_out, rd_phy_old_1_out,
    output phy_reg_t    rd_phy_new_0_out, rd_phy_new_1_out,
    output logic        store_valid_0, store_valid_1,
    output store_id_t   store_id_0_out, store_id_1_out,
    output logic        branch_valid_0, branch_valid_1,
    output addr_t       btb_pc_0, btb_pc_1,
    output logic        btb_taken_0, btb_taken_1,
    output addr_t       btb_target_0, btb_target_1,
    output logic        redirect_0, redirect_1,
    output addr_t       redirect_pc_0, redirect_pc_1,
    output logic        done_valid_0, done_valid_1
);

    inst_class_e dec_inst_class_0, dec_inst_class_1;
    logic        dec_pr_valid_0, dec_pr_valid_1;
    arch_reg_t   dec_rd_arch_0, dec_rd_arch_1;
    phy_reg_t    dec_rd_phy_old_0, dec_rd_phy_old_1;
    phy_reg_t    dec_rd_phy_new_0, dec_rd_phy_new_1;
    logic        dec_store_valid_0, dec_store_valid_1;
    store_id_t   dec_store_id_0, dec_store_id_1;
    logic        dec_branch_valid_0, dec_branch_valid_1;
    addr_t       dec_btb_pc_0, dec_btb_pc_1;
    logic        dec_btb_taken_0, dec_btb_taken_1;
    addr_t       dec_btb_target_0, dec_btb_target_1;
    logic        dec_redirect_0, dec_redirect_1;
    addr_t       dec_redirect_pc_0, dec_redirect_pc_1;
    logic        dec_done_valid_0, dec_done_valid_1;

    // ############################################################
    // Slot decoders
    // ############################################################

    retire_slot_decode slot0_decode (
        .opcode         (opcode_0),
        .rd_arch        (rd_arch_0),
        .rd_phy_old     (rd_phy_old_0),
        .rd_phy_new     (rd_phy_new_0),
        .store_id       (store_id_0),
        .update_pc      (update_pc_0),
        .actual_target  (actual_target_0),
        .actual_taken   (actual_taken_0),
        .mispredict     (mispredict_0),
        .inst_class     (dec_inst_class_0),
        .pr_valid       (dec_pr_valid_0),
        .rd_arch_out    (dec_rd_arch_0),
        .rd_phy_old_out (dec_rd_phy_old_0),
        .rd_phy_new_out (dec_rd_phy_new_0),
        .store_valid    (dec_store_valid_0),
        .store_id_out   (dec_store_id_0),
        .branch_valid   (dec_branch_valid_0),
        .btb_pc         (dec_btb_pc_0),
        .btb_taken      (dec_btb_taken_0),
        .btb_target     (dec_btb_target_0),
        .redirect       (dec_redirect_0),
        .redirect_pc    (dec_redirect_pc_0),
        .done_valid     (dec_done_valid_0)
    );

    retire_slot_decode slot1_decode (
        .opcode         (opcode_1),
        .rd_arch        (rd_arch_1),
        .rd_phy_old     (rd_phy_old_1),
        .rd_phy_new     (rd_phy_new_1),
        .store_id       (store_id_1),
        .update_pc      (update_pc_1),
        .actual_target  (actual_target_1),
        .actual_taken   (actual_taken_1),
        .mispredict     (mispredict_1),
        .inst_class     (dec_inst_class_1),
        .pr_valid       (dec_pr_valid_1),
        .rd_arch_out    (dec_rd_arch_1),
        .rd_phy_old_out (dec_rd_phy_old_1),
        .rd_phy_new_out (dec_rd_phy_new_1),
        .store_valid    (dec_store_valid_1),
        .store_id_out   (dec_store_id_1),
        .branch_valid   (dec_branch_valid_1),
        .btb_pc         (dec_btb_pc_1),
        .btb_taken      (dec_btb_taken_1),
        .btb_target     (dec_btb_target_1),
        .redirect       (dec_redirect_1),
        .redirect_pc    (dec_redirect_pc_1),
        .done_valid     (dec_done_valid_1)
    );

    // Port names match the wires and top-level ports one to one
    retire_select retire_sel (.*);

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 20;           // 40 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;                        // Release clear of the edge
    end

endmodule

`default_nettype wire

// ==== retire_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module retire_assertions
    import retire_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input retire_num_t retire_num,
    input logic        pr_valid_1,
    input logic        redirect_0,
    input logic        redirect_1
);

    int unsigned fail_count = 0;

    // Only two ROB entries are visible
    num_in_range: assert property (@(posedge clk) disable iff (!rst_n) retire_num != 2'd3)
        else begin
            $error("retire_num is 3, more than two entries retired");
            fail_count++;
        end

    slot1_needs_dual: assert property (@(posedge clk) disable iff (!rst_n)
        pr_valid_1 |-> retire_num == 2'd2)
        else begin
            $error("pr_valid_1 is high while retire_num is not 2");
            fail_count++;
        end

    // A redirect in slot 0 flushes slot 1
    single_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        !(redirect_0 && redirect_1))
        else begin
            $error("redirect_0 and redirect_1 are both high");
            fail_count++;
        end

endmodule

bind retire_select retire_assertions retire_checks (.*);

`default_nettype wire

// ==== retire_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module retire_unit_tb
    import retire_pkg::*;
();

    localparam int NUM_CYCLES   = 2000;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int TIMEOUT_NS   = (NUM_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;

    typedef struct packed {
        logic      pr_valid;
        arch_reg_t rd_arch;
        phy_reg_t  rd_phy_old;
        phy_reg_t  rd_phy_new;
        logic      store_valid;
        store_id_t store_id;
        logic      branch_valid;
        addr_t     btb_pc;
        logic      btb_taken;
        addr_t     btb_target;
        logic      redirect;
        addr_t     redirect_pc;
        logic      done_valid;
    } slot_rec_t;

    typedef struct packed {
        retire_num_t num;
        slot_rec_t   s0;
        slot_rec_t   s1;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        flush = 1'b0;
    logic        finish_0 = 1'b0, finish_1 = 1'b0;
    opcode_e     opcode_0 = OP_IMM, opcode_1 = OP_IMM;
    arch_reg_t   rd_arch_0 = '0, rd_arch_1 = '0;
    phy_reg_t    rd_phy_old_0 = '0, rd_phy_old_1 = '0;
    phy_reg_t    rd_phy_new_0 = '0, rd_phy_new_1 = '0;
    store_id_t   store_id_0 = '0, store_id_1 = '0;
    addr_t       update_pc_0 = '0, update_pc_1 = '0;
    logic        actual_taken_0 = 1'b0, actual_taken_1 = 1'b0;
    addr_t       actual_target_0 = '0, actual_target_1 = '0;
    logic        mispredict_0 = 1'b0, mispredict_1 = 1'b0;

    retire_num_t retire_num;
    logic        pr_valid_0, pr_valid_1;
    arch_reg_t   rd_arch_0_out, rd_arch_1_out;
    phy_reg_t    rd_phy_old_0_out, rd_phy_old_1_out;
    phy_reg_t    rd_phy_new_0_out, rd_phy_new_1_out;
    logic        store_valid_0, store_valid_1;
    store_id_t   store_id_0_out, store_id_1_out;
    logic        branch_valid_0, branch_valid_1;
    addr_t       btb_pc_0, btb_pc_1;
    logic        btb_taken_0, btb_taken_1;
    addr_t       btb_target_0, btb_target_1;
    logic        redirect_0, redirect_1;
    addr_t       redirect_pc_0, redirect_pc_1;
    logic        done_valid_0, done_valid_1;

    integer      seed = 32'hd68959e3;
    int          errors = 0;
    expect_t     exp_q[$];
    opcode_e     legal_ops[10] = '{OP_IMM, OP, LUI, AUIPC, LOAD, STORE, BRANCH, JAL, JALR, SYSTEM};
    logic [6:0]  illegal_ops[4] = '{7'h00, 7'h0f, 7'h2f, 7'h7f};    // Not in the retire table

    tb_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

    retire_unit retire_unit_i (.*);

    // ############################################################
    // Reference model
    // ############################################################

    function automatic inst_class_e class_of(input opcode_e op);
        case (op)
            OP_IMM, OP, LUI, AUIPC: return CLASS_ALU;
            LOAD:                   return CLASS_LOAD;
            STORE:                  return CLASS_STORE;
            BRANCH:                 return CLASS_BRANCH;
            JAL, JALR:              return CLASS_JUMP;
            SYSTEM:                 return CLASS_SYSTEM;
            default:                return CLASS_OTHER;
        endcase
    endfunction

    function automatic slot_rec_t expected_record(input inst_class_e cls, input arch_reg_t rd,
            input phy_reg_t old_p, input phy_reg_t new_p, input store_id_t sid,
            input addr_t pc, input logic taken, input addr_t tgt, input logic misp);
        slot_rec_t r;
        r = '0;
        if (cls == CLASS_ALU || cls == CLASS_LOAD || (cls == CLASS_JUMP && rd != 0)) begin
            r.pr_valid   = 1'b1;
            r.rd_arch    = rd;
            r.rd_phy_old = old_p;
            r.rd_phy_new = new_p;
        end
        if (cls == CLASS_STORE) begin
            r.store_valid = 1'b1;
            r.store_id    = sid;
        end
        if (cls == CLASS_BRANCH || cls == CLASS_JUMP) begin
            r.branch_valid = 1'b1;
            r.btb_pc       = pc;
            r.btb_taken    = taken;
            r.btb_target   = tgt;
            r.redirect     = misp;
            r.redirect_pc  = misp ? tgt : '0;
        end
        r.done_valid = (cls == CLASS_SYSTEM);
        return r;
    endfunction

    // ############################################################
    // Checks
    // ############################################################

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] act,
            input logic [31:0] exp);
        assert (act === exp) else begin
            errors++;
            stop_on_error($sformatf("FAILED at time %0d ns: %s is %0h, expected %0h",
                                    $time, name, act, exp));
        end
    endtask

    task automatic compare_slot(input string n, input slot_rec_t act, input slot_rec_t exp);
        check_field({"pr_valid_", n}, act.pr_valid, exp.pr_valid);
        check_field({"rd_arch_", n, "_out"}, act.rd_arch, exp.rd_arch);
        check_field({"rd_phy_old_", n, "_out"}, act.rd_phy_old, exp.rd_phy_old);
        check_field({"rd_phy_new_", n, "_out"}, act.rd_phy_new, exp.rd_phy_new);
        check_field({"store_valid_", n}, act.store_valid, exp.store_valid);
        check_field({"store_id_", n, "_out"}, act.store_id, exp.store_id);
        check_field({"branch_valid_", n}, act.branch_valid, exp.branch_valid);
        check_field({"btb_pc_", n}, act.btb_pc, exp.btb_pc);
        check_field({"btb_taken_", n}, act.btb_taken, exp.btb_taken);
        check_field({"btb_target_", n}, act.btb_target, exp.btb_target);
        check_field({"redirect_", n}, act.redirect, exp.redirect);
        check_field({"redirect_pc_", n}, act.redirect_pc, exp.redirect_pc);
        check_field({"done_valid_", n}, act.done_valid, exp.done_valid);
    endtask

    task automatic check_outputs(input expect_t e);
        slot_rec_t act0;
        slot_rec_t act1;
        act0 = {pr_valid_0, rd_arch_0_out, rd_phy_old_0_out, rd_phy_new_0_out, store_valid_0,
                store_id_0_out, branch_valid_0, btb_pc_0, btb_taken_0, btb_target_0,
                redirect_0, redirect_pc_0, done_valid_0};
        act1 = {pr_valid_1, rd_arch_1_out, rd_phy_old_1_out, rd_phy_new_1_out, store_valid_1,
                store_id_1_out, branch_valid_1, btb_pc_1, btb_taken_1, btb_target_1,
                redirect_1, redirect_pc_1, done_valid_1};
        check_field("retire_num", retire_num, e.num);
        compare_slot("0", act0, e.s0);
        compare_slot("1", act1, e.s1);
    endtask

    // Concurrent checks in the bound checker
    always @(retire_unit_i.retire_sel.retire_checks.fail_count) begin
        assert (retire_unit_i.retire_sel.retire_checks.fail_count == 0) else begin
            errors++;
            stop_on_error("A concurrent assertion on the retire bus failed");
        end
    end

    // ############################################################
    // Stimulus
    // ############################################################

    task automatic random_entry(output logic fin, output opcode_e op, output arch_reg_t rd,
            output phy_reg_t old_p, output phy_reg_t new_p, output store_id_t sid,
            output addr_t pc, output logic taken, output addr_t tgt, output logic misp);
        int unsigned pick;
        pick = {$random(seed)} % 100;
        if (pick < 6)
            op = opcode_e'(illegal_ops[pick % 4]);
        else
            op = legal_ops[pick % 10];
        fin   = ({$random(seed)} % 4) != 0;         // Finished 3 times in 4
        rd    = ({$random(seed)} % 10 == 0) ? '0 : arch_reg_t'($random(seed));
        old_p = phy_reg_t'($random(seed));
        new_p = phy_reg_t'($random(seed));
        sid   = store_id_t'($random(seed));
        pc    = addr_t'($random(seed));
        taken = ({$random(seed)} % 2) != 0;
        tgt   = addr_t'($random(seed));
        misp  = ({$random(seed)} % 5) == 0;
    endtask

    task automatic drive_cycle();
        expect_t     e;
        slot_rec_t   rec0;
        slot_rec_t   rec1;
        inst_class_e cls0;
        inst_class_e cls1;
        logic        blocked;
        logic        take0;
        logic        take1;
        random_entry(finish_0, opcode_0, rd_arch_0, rd_phy_old_0, rd_phy_new_0, store_id_0,
                     update_pc_0, actual_taken_0, actual_target_0, mispredict_0);
        random_entry(finish_1, opcode_1, rd_arch_1, rd_phy_old_1, rd_phy_new_1, store_id_1,
                     update_pc_1, actual_taken_1, actual_target_1, mispredict_1);
        if ({$random(seed)} % 4 == 0)
            opcode_1 = opcode_0;                    // Same-class pairs
        flush = ({$random(seed)} % 100) < 5;
        cls0 = class_of(opcode_0);
        cls1 = class_of(opcode_1);
        rec0 = expected_record(cls0, rd_arch_0, rd_phy_old_0, rd_phy_new_0, store_id_0,
                               update_pc_0, actual_taken_0, actual_target_0, mispredict_0);
        rec1 = expected_record(cls1, rd_arch_1, rd_phy_old_1, rd_phy_new_1, store_id_1,
                               update_pc_1, actual_taken_1, actual_target_1, mispredict_1);
        blocked = (cls0 == cls1 && (cls0 == CLASS_STORE || cls0 == CLASS_BRANCH ||
                   cls0 == CLASS_JUMP || cls0 == CLASS_SYSTEM)) || rec0.redirect;
        take0 = !flush && finish_0;
        take1 = take0 && finish_1 && !blocked;
        e.num = take1 ? 2'd2 : (take0 ? 2'd1 : 2'd0);
        e.s0  = take0 ? rec0 : '0;
        e.s1  = take1 ? rec1 : '0;
        exp_q.push_back(e);
    endtask

    initial begin
        @(posedge rst_n);
        #1;
        check_outputs('0);                          // Reset state
        for (int i = 0; i <= NUM_CYCLES; i++) begin
            @(posedge clk);
            #1;
            if (exp_q.size() > 0)
                check_outputs(exp_q.pop_front());
            if (i < NUM_CYCLES) begin
                #1;
                drive_cycle();
            end
        end
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        stop_on_error("Timeout: the test loop did not complete in the expected time");
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
retire_pkg.sv
retire_slot_decode.sv
retire_select.sv
retire_unit.sv
tb_clock_gen.sv
retire_assertions.sv
retire_unit_tb.sv
